// ==== vctrl_params.svh ====
/*
  Width, opcode and CSR address constants of the vector issue controller.
  Included by the package and by every module that needs a width or an
  encoding. Values follow the RVV 1.0 subset this controller decodes.
*/
`ifndef VCTRL_PARAMS_SVH
`define VCTRL_PARAMS_SVH

// Scalar side
`define XLEN      32
`define ID_WIDTH  4

// Vector geometry
`define ELEN      32
`define VLEN_BITS 256
`define VLENB     (`VLEN_BITS / 8)
// Holds vl up to LMUL 8 at SEW 8
`define VL_WIDTH  9

////////////////////
// Major opcodes
////////////////////
`define OPC_OPV      7'h57
`define OPC_LOAD_FP  7'h07
`define OPC_STORE_FP 7'h27
`define OPC_SYSTEM   7'h73

////////////////////
// Vector CSRs
////////////////////
`define CSR_VSTART 12'h008
`define CSR_VL     12'hC20
`define CSR_VTYPE  12'hC21
`define CSR_VLENB  12'hC22

`endif

// ==== vctrl_pkg.sv ====
/*
  Shared types of the vector issue controller: unit, operation and CSR
  access enums, the vtype register layout and the structs that travel
  between the core, the decoder, the buffer and the execution units.
*/
`include "vctrl_params.svh"

package vctrl_pkg;

  // Destination of a decoded operation
  typedef enum logic [1:0] {
    CON = 2'd0,
    VFU = 2'd1,
    LSU = 2'd2,
    SLD = 2'd3
  } ex_unit_e;

  typedef enum logic [2:0] {
    VCFG   = 3'd0,
    VCSR   = 3'd1,
    VARITH = 3'd2,
    VLOAD  = 3'd3,
    VSTORE = 3'd4,
    VSLIDE = 3'd5
  } op_e;

  // Codes match funct3[1:0] of csrrw, csrrs, csrrc
  typedef enum logic [1:0] {
    CSR_WRITE = 2'd1,
    CSR_SET   = 2'd2,
    CSR_CLEAR = 2'd3
  } csr_op_e;

  // Codes 3 and above are reserved
  typedef enum logic [2:0] {
    EW_8  = 3'd0,
    EW_16 = 3'd1,
    EW_32 = 3'd2
  } vew_e;

  typedef enum logic [2:0] {
    LMUL_1   = 3'd0,
    LMUL_2   = 3'd1,
    LMUL_4   = 3'd2,
    LMUL_8   = 3'd3,
    LMUL_RES = 3'd4,
    LMUL_F8  = 3'd5,
    LMUL_F4  = 3'd6,
    LMUL_F2  = 3'd7
  } vlmul_e;

  typedef struct packed {
    logic   vill;
    vew_e   vsew;
    vlmul_e vlmul;
  } vtype_t;

  ////////////////////
  // Core interface
  ////////////////////

  typedef struct packed {
    logic [31:0]          instr;
    logic [`XLEN-1:0]     rs1;
    logic [`ID_WIDTH-1:0] id;
  } issue_req_t;

  typedef struct packed {
    logic accept;
    logic writeback;
    logic loadstore;
  } issue_resp_t;

  typedef struct packed {
    logic [`ID_WIDTH-1:0] id;
    logic [4:0]           rd;
    logic [`XLEN-1:0]     data;
    logic                 we;
  } result_t;

  // One decoded operation, also the request sent to the units
  typedef struct packed {
    op_e                  op;
    ex_unit_e             ex_unit;
    logic [4:0]           vd;
    logic [4:0]           vs1;
    logic [4:0]           vs2;
    logic [4:0]           rd;
    logic                 use_vs1;
    logic                 use_vs2;
    logic                 use_vd;
    logic                 vd_is_src;
    logic                 use_rd;
    logic [`XLEN-1:0]     rs1;
    logic [11:0]          csr_addr;
    csr_op_e              csr_op;
    logic [`ID_WIDTH-1:0] id;
    vtype_t               vtype;
    logic [`VL_WIDTH-1:0] vl;
    logic [`VL_WIDTH-1:0] vstart;
  } vreq_t;

endpackage

// ==== vinstr_decoder.sv ====
/*
  Combinational decoder for the vector subset: vsetvli, vector CSR
  accesses, OPV arithmetic and slides, and unit-width vector loads and
  stores. Drives a decoded request and an illegal flag to the issue logic.
*/
`timescale 1ns/1ps
`include "vctrl_params.svh"

module vinstr_decoder (
  input  vctrl_pkg::issue_req_t issue_req_i,
  output vctrl_pkg::vreq_t      dec_req_o,
  output logic                  illegal_o
);

  import vctrl_pkg::*;

  logic [31:0] instr;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [5:0]  funct6;
  logic [4:0]  rd_f;
  logic [4:0]  rs1_f;
  logic [4:0]  rs2_f;
  logic [11:0] csr_addr;
  logic        csr_known;
  logic        is_slide;

  assign instr    = issue_req_i.instr;
  assign opcode   = instr[6:0];
  assign rd_f     = instr[11:7];
  assign funct3   = instr[14:12];
  assign rs1_f    = instr[19:15];
  assign rs2_f    = instr[24:20];
  assign funct6   = instr[31:26];
  assign csr_addr = instr[31:20];

  assign csr_known = (csr_addr == `CSR_VSTART) || (csr_addr == `CSR_VL) ||
                     (csr_addr == `CSR_VTYPE)  || (csr_addr == `CSR_VLENB);

  // vslideup / vslidedown
  assign is_slide = (funct6 == 6'h0E) || (funct6 == 6'h0F);

  always_comb begin
    dec_req_o     = '0;
    dec_req_o.rs1 = issue_req_i.rs1;
    dec_req_o.id  = issue_req_i.id;
    illegal_o     = 1'b1;

    case (opcode)
      `OPC_OPV: begin
        if (funct3 == 3'd7) begin
          // Only vsetvli, and not the keep-vl form
          if (!instr[31] && ((rs1_f != 5'd0) || (rd_f != 5'd0))) begin
            illegal_o              = 1'b0;
            dec_req_o.op           = VCFG;
            dec_req_o.ex_unit      = CON;
            dec_req_o.rd           = rd_f;
            dec_req_o.use_rd       = (rd_f != 5'd0);
            dec_req_o.vtype.vsew   = vew_e'(instr[25:23]);
            dec_req_o.vtype.vlmul  = vlmul_e'(instr[22:20]);
            // rs1 = x0 requests vlmax
            if (rs1_f == 5'd0) begin
              dec_req_o.rs1 = '1;
            end
          end
        end else begin
          illegal_o         = 1'b0;
          dec_req_o.op      = is_slide ? VSLIDE : VARITH;
          dec_req_o.ex_unit = is_slide ? SLD : VFU;
          dec_req_o.vd      = rd_f;
          dec_req_o.vs1     = rs1_f;
          dec_req_o.vs2     = rs2_f;
          dec_req_o.use_vd  = 1'b1;
          dec_req_o.use_vs2 = 1'b1;
          // Vector-vector forms (OPIVV, OPFVV, OPMVV) read vs1
          dec_req_o.use_vs1 = (funct3 <= 3'd2) && !is_slide;
        end
      end

      `OPC_LOAD_FP, `OPC_STORE_FP: begin
        if (funct3 inside {3'd0, 3'd5, 3'd6}) begin
          illegal_o           = 1'b0;
          dec_req_o.op        = (opcode == `OPC_STORE_FP) ? VSTORE : VLOAD;
          dec_req_o.ex_unit   = LSU;
          dec_req_o.vd        = rd_f;
          dec_req_o.vs2       = rs2_f;
          dec_req_o.use_vd    = 1'b1;
          dec_req_o.vd_is_src = (opcode == `OPC_STORE_FP);
          // Indexed modes use vs2 as the offset vector
          dec_req_o.use_vs2   = instr[26];
          case (funct3)
            3'd0:    dec_req_o.vtype.vsew = EW_8;
            3'd5:    dec_req_o.vtype.vsew = EW_16;
            default: dec_req_o.vtype.vsew = EW_32;
          endcase
        end
      end

      `OPC_SYSTEM: begin
        if ((funct3 inside {3'd1, 3'd2, 3'd3}) && csr_known) begin
          dec_req_o.op       = VCSR;
          dec_req_o.ex_unit  = CON;
          dec_req_o.rd       = rd_f;
          dec_req_o.use_rd   = (rd_f != 5'd0);
          dec_req_o.csr_addr = csr_addr;
          dec_req_o.csr_op   = csr_op_e'(funct3[1:0]);
          // Only vstart is writable
          illegal_o = (rs1_f != 5'd0) && (csr_addr != `CSR_VSTART);
        end
      end

      default: illegal_o = 1'b1;
    endcase
  end

endmodule

// ==== vcsr_file.sv ====
/*
  vstart, vl and vtype registers. A commit strobe applies the popped
  request: vsetvli sets vtype and vl, CSR accesses update vstart, any
  vector operation clears vstart. rdata_o returns the value for rd.
*/
`timescale 1ns/1ps
`include "vctrl_params.svh"

module vcsr_file (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 commit_i,
  input  vctrl_pkg::vreq_t     req_i,
  output vctrl_pkg::vtype_t    vtype_o,
  output logic [`VL_WIDTH-1:0] vl_o,
  output logic [`VL_WIDTH-1:0] vstart_o,
  output logic [`XLEN-1:0]     rdata_o
);

  import vctrl_pkg::*;

  localparam int ElenLog = $clog2(`ELEN);

  vtype_t               vtype_q;
  logic [`VL_WIDTH-1:0] vl_q;
  logic [`VL_WIDTH-1:0] vstart_q;

  int                   lmul_exp;
  logic                 cfg_bad;
  logic [`VL_WIDTH-1:0] vlmax;
  logic [`VL_WIDTH-1:0] cfg_vl;
  logic [`VL_WIDTH-1:0] csr_wdata;

  ////////////////////
  // vsetvli rule
  ////////////////////

  always_comb begin
    case (req_i.vtype.vlmul)
      LMUL_1:  lmul_exp = 0;
      LMUL_2:  lmul_exp = 1;
      LMUL_4:  lmul_exp = 2;
      LMUL_8:  lmul_exp = 3;
      LMUL_F2: lmul_exp = -1;
      LMUL_F4: lmul_exp = -2;
      default: lmul_exp = -3;
    endcase

    // LMUL * ELEN must cover SEW
    cfg_bad = (req_i.vtype.vsew > EW_32) ||
              (req_i.vtype.vlmul inside {LMUL_RES, LMUL_F8}) ||
              ((lmul_exp + ElenLog) < (3 + int'(req_i.vtype.vsew)));

    // Elements per register, then scaled by LMUL
    vlmax = `VL_WIDTH'(`VLENB) >> req_i.vtype.vsew;
    if (lmul_exp >= 0) begin
      vlmax = vlmax << lmul_exp;
    end else begin
      vlmax = vlmax >> (-lmul_exp);
    end

    if (cfg_bad) begin
      cfg_vl = '0;
    end else if (req_i.rs1 == '1) begin
      cfg_vl = vlmax;
    end else if (req_i.rs1 < `XLEN'(vlmax)) begin
      cfg_vl = req_i.rs1[`VL_WIDTH-1:0];
    end else begin
      cfg_vl = vlmax;
    end
  end

  // New vstart for a CSR access
  always_comb begin
    case (req_i.csr_op)
      CSR_SET:   csr_wdata = vstart_q | req_i.rs1[`VL_WIDTH-1:0];
      CSR_CLEAR: csr_wdata = vstart_q & ~req_i.rs1[`VL_WIDTH-1:0];
      default:   csr_wdata = req_i.rs1[`VL_WIDTH-1:0];
    endcase
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      vtype_q  <= '{vill: 1'b1, vsew: EW_8, vlmul: LMUL_1};
      vl_q     <= '0;
      vstart_q <= '0;
    end else if (commit_i) begin
      case (req_i.op)
        VCFG: begin
          if (cfg_bad) begin
            vtype_q <= '{vill: 1'b1, vsew: EW_8, vlmul: LMUL_1};
          end else begin
            vtype_q <= '{vill: 1'b0, vsew: req_i.vtype.vsew, vlmul: req_i.vtype.vlmul};
          end
          vl_q <= cfg_vl;
        end
        VCSR: begin
          if (req_i.csr_addr == `CSR_VSTART) begin
            vstart_q <= csr_wdata;
          end
        end
        default: vstart_q <= '0;
      endcase
    end
  end

  // Read value: new vl for vsetvli, old CSR value otherwise
  always_comb begin
    rdata_o = '0;
    if (req_i.op == VCFG) begin
      rdata_o = `XLEN'(cfg_vl);
    end else if (req_i.op == VCSR) begin
      case (req_i.csr_addr)
        `CSR_VSTART: rdata_o = `XLEN'(vstart_q);
        `CSR_VL:     rdata_o = `XLEN'(vl_q);
        `CSR_VTYPE:  rdata_o = {vtype_q.vill, {(`XLEN-7){1'b0}}, vtype_q.vsew, vtype_q.vlmul};
        `CSR_VLENB:  rdata_o = `XLEN'(`VLENB);
        default:     rdata_o = '0;
      endcase
    end
  end

  assign vtype_o  = vtype_q;
  assign vl_o     = vl_q;
  assign vstart_o = vstart_q;

endmodule

// ==== vreq_buffer.sv ====
/*
  One-entry fall-through buffer for decoded requests. A push into the
  empty buffer is visible on data_o in the same cycle and may pop at once;
  otherwise the entry is held until pop_i.
*/
`timescale 1ns/1ps

module vreq_buffer (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             push_i,
  input  logic             pop_i,
  input  vctrl_pkg::vreq_t data_i,
  output logic             empty_o,
  output logic             valid_o,
  output vctrl_pkg::vreq_t data_o
);

  import vctrl_pkg::*;

  logic  full_q;
  vreq_t data_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else begin
      full_q <= (full_q | push_i) & ~pop_i;
    end
  end

  // Captured on a push into the empty buffer
  always_ff @(posedge clk_i) begin
    if (push_i && !full_q) begin
      data_q <= data_i;
    end
  end

  assign empty_o = ~full_q;
  assign valid_o = full_q | push_i;
  assign data_o  = full_q ? data_q : data_i;

endmodule

// ==== issue_ctrl.sv ====
/*
  Issue control: answers the core's issue request, pushes accepted work
  into the buffer, pops it when the target unit can take it, and either
  dispatches it to a vector unit or retires it with a result to the core.
*/
`timescale 1ns/1ps
`include "vctrl_params.svh"

module issue_ctrl (
  input  logic                   issue_valid_i,
  input  logic                   illegal_i,
  input  vctrl_pkg::vreq_t       dec_req_i,
  input  logic                   buf_empty_i,
  input  logic                   buf_valid_i,
  input  vctrl_pkg::vreq_t       buf_req_i,
  input  vctrl_pkg::vtype_t      vtype_i,
  input  logic [`VL_WIDTH-1:0]   vl_i,
  input  logic [`VL_WIDTH-1:0]   vstart_i,
  input  logic [`XLEN-1:0]       rdata_i,
  input  logic                   vfu_ready_i,
  input  logic                   vlsu_ready_i,
  input  logic                   vsldu_ready_i,
  output logic                   issue_ready_o,
  output logic                   push_o,
  output logic                   pop_o,
  output logic                   commit_o,
  output logic                   vreq_valid_o,
  output logic                   result_valid_o,
  output vctrl_pkg::issue_resp_t issue_resp_o,
  output vctrl_pkg::vreq_t       vreq_o,
  output vctrl_pkg::result_t     result_o
);

  import vctrl_pkg::*;

  logic accept;
  logic all_ready;
  logic unit_stall;
  logic cfg_stall;

  ////////////////////
  // Issue response
  ////////////////////

  // Vector work needs a legal vtype
  assign accept = issue_valid_i & ~illegal_i & ((dec_req_i.ex_unit == CON) | ~vtype_i.vill);

  assign issue_ready_o = buf_empty_i;
  assign push_o        = accept & buf_empty_i;

  always_comb begin
    issue_resp_o = '0;
    if (push_o) begin
      issue_resp_o.accept    = 1'b1;
      issue_resp_o.writeback = (dec_req_i.ex_unit == CON) & dec_req_i.use_rd;
      issue_resp_o.loadstore = (dec_req_i.ex_unit == LSU);
    end
  end

  ////////////////////
  // Stalls and pop
  ////////////////////

  assign all_ready = vfu_ready_i & vlsu_ready_i & vsldu_ready_i;

  always_comb begin
    case (buf_req_i.ex_unit)
      VFU:     unit_stall = ~vfu_ready_i;
      LSU:     unit_stall = ~vlsu_ready_i;
      SLD:     unit_stall = ~vsldu_ready_i;
      default: unit_stall = 1'b0;
    endcase
  end

  // An LMUL change drains every unit first
  assign cfg_stall = (buf_req_i.op == VCFG) & (buf_req_i.vtype.vlmul != vtype_i.vlmul) &
                     ~all_ready;

  assign pop_o          = buf_valid_i & ~unit_stall & ~cfg_stall;
  assign commit_o       = pop_o;
  assign vreq_valid_o   = pop_o & (buf_req_i.ex_unit != CON);
  assign result_valid_o = pop_o & (buf_req_i.ex_unit == CON);

  // Current CSR state goes with each dispatched request
  always_comb begin
    vreq_o        = buf_req_i;
    vreq_o.vl     = vl_i;
    vreq_o.vstart = vstart_i;
    if (buf_req_i.ex_unit == LSU) begin
      // Element width stays as encoded in the load or store
      vreq_o.vtype.vill  = vtype_i.vill;
      vreq_o.vtype.vlmul = vtype_i.vlmul;
    end else if (buf_req_i.ex_unit != CON) begin
      vreq_o.vtype = vtype_i;
    end
  end

  assign result_o = '{id: buf_req_i.id, rd: buf_req_i.rd, data: rdata_i, we: 1'b1};

endmodule

// ==== vctrl_top.sv ====
/*
  Top level of the vector issue controller. Connects the decoder, the
  CSR file, the request buffer and the issue logic between the core's
  issue and result ports and the three execution unit request ports.
*/
`timescale 1ns/1ps
`include "vctrl_params.svh"

module vctrl_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   issue_valid_i,
  input  vctrl_pkg::issue_req_t  issue_req_i,
  output logic                   issue_ready_o,
  output vctrl_pkg::issue_resp_t issue_resp_o,
  output logic                   result_valid_o,
  output vctrl_pkg::result_t     result_o,
  output logic                   vreq_valid_o,
  output vctrl_pkg::vreq_t       vreq_o,
  input  logic                   vfu_ready_i,
  input  logic                   vlsu_ready_i,
  input  logic                   vsldu_ready_i
);

  import vctrl_pkg::*;

  vreq_t                dec_req;
  logic                 dec_illegal;
  vreq_t                buf_req;
  logic                 buf_empty;
  logic                 buf_valid;
  logic                 push;
  logic                 pop;
  logic                 commit;
  vtype_t               vtype;
  logic [`VL_WIDTH-1:0] vl;
  logic [`VL_WIDTH-1:0] vstart;
  logic [`XLEN-1:0]     rdata;

  vinstr_decoder u_decoder (
    .issue_req_i (issue_req_i),
    .dec_req_o   (dec_req),
    .illegal_o   (dec_illegal)
  );

  vreq_buffer u_buffer (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (push),
    .pop_i   (pop),
    .data_i  (dec_req),
    .empty_o (buf_empty),
    .valid_o (buf_valid),
    .data_o  (buf_req)
  );

  // Sees the request leaving the buffer
  vcsr_file u_csr (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .commit_i (commit),
    .req_i    (buf_req),
    .vtype_o  (vtype),
    .vl_o     (vl),
    .vstart_o (vstart),
    .rdata_o  (rdata)
  );

  issue_ctrl u_issue (
    .issue_valid_i  (issue_valid_i),
    .illegal_i      (dec_illegal),
    .dec_req_i      (dec_req),
    .buf_empty_i    (buf_empty),
    .buf_valid_i    (buf_valid),
    .buf_req_i      (buf_req),
    .vtype_i        (vtype),
    .vl_i           (vl),
    .vstart_i       (vstart),
    .rdata_i        (rdata),
    .vfu_ready_i    (vfu_ready_i),
    .vlsu_ready_i   (vlsu_ready_i),
    .vsldu_ready_i  (vsldu_ready_i),
    .issue_ready_o  (issue_ready_o),
    .push_o         (push),
    .pop_o          (pop),
    .commit_o       (commit),
    .vreq_valid_o   (vreq_valid_o),
    .result_valid_o (result_valid_o),
    .issue_resp_o   (issue_resp_o),
    .vreq_o         (vreq_o),
    .result_o       (result_o)
  );

endmodule

// ==== tb_vctrl.sv ====
/*
  Self-checking testbench for the vector issue controller. A table of
  instructions with expected responses is issued one row at a time; each
  row is followed to its result or dispatch pulse, with LFSR-driven unit
  ready levels in the back-pressure rows and a cycle limit on the run.
*/
`timescale 1ns/1ps

module tb_vctrl;

  import vctrl_pkg::*;

  localparam int NUM_ROWS       = 31;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 64;

  // Expected outcome of a row
  localparam int K_NONE = 0;
  localparam int K_RES  = 1;
  localparam int K_VFU  = 2;
  localparam int K_LSU  = 3;
  localparam int K_SLD  = 4;

  // Ready patterns: 0 all high, 1 random, 2 random and all high at retire
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] rs1;
    logic [1:0]  sel;
    logic        accept;
    logic [2:0]  kind;
    logic [31:0] data;
    logic [31:0] vstart;
    logic [2:0]  sew;
  } row_t;

  logic        clk_i;
  logic        rst_n_i;
  logic        issue_valid_i;
  issue_req_t  issue_req_i;
  logic        issue_ready_o;
  issue_resp_t issue_resp_o;
  logic        result_valid_o;
  result_t     result_o;
  logic        vreq_valid_o;
  vreq_t       vreq_o;
  logic        vfu_ready_i;
  logic        vlsu_ready_i;
  logic        vsldu_ready_i;

  row_t        rows [NUM_ROWS];
  logic [31:0] lfsr_q;
  logic [2:0]  cur_lmul;
  int          cycle_cnt;
  int          err_cnt;
  int          tests_failed;

  vctrl_top uut (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .issue_valid_i  (issue_valid_i),
    .issue_req_i    (issue_req_i),
    .issue_ready_o  (issue_ready_o),
    .issue_resp_o   (issue_resp_o),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .vreq_valid_o   (vreq_valid_o),
    .vreq_o         (vreq_o),
    .vfu_ready_i    (vfu_ready_i),
    .vlsu_ready_i   (vlsu_ready_i),
    .vsldu_ready_i  (vsldu_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT never finished the table", cycle_cnt);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  ////////////////////
  // Encoders
  ////////////////////

  function automatic logic [31:0] enc_vsetvli(input int rd, input int rs1, input int sew,
                                              input int lmul);
    enc_vsetvli = {1'b0, 5'b00000, 3'(sew), 3'(lmul), 5'(rs1), 3'b111, 5'(rd), 7'h57};
  endfunction

  function automatic logic [31:0] enc_csr(input int f3, input int addr, input int rs1,
                                          input int rd);
    enc_csr = {12'(addr), 5'(rs1), 3'(f3), 5'(rd), 7'h73};
  endfunction

  function automatic logic [31:0] enc_opv(input int f6, input int vs2, input int vs1,
                                          input int f3, input int vd);
    enc_opv = {6'(f6), 1'b1, 5'(vs2), 5'(vs1), 3'(f3), 5'(vd), 7'h57};
  endfunction

  // Unit-stride load or store
  function automatic logic [31:0] enc_vmem(input int opc, input int width, input int rs1,
                                           input int vd);
    enc_vmem = {6'b000000, 1'b1, 5'b00000, 5'(rs1), 3'(width), 5'(vd), 7'(opc)};
  endfunction

  function automatic row_t make_row(input logic [31:0] instr, input int rs1, input int sel,
                                    input int acc, input int kind, input int data,
                                    input int vstart, input int sew);
    make_row = '{instr: instr, rs1: 32'(rs1), sel: 2'(sel), accept: 1'(acc),
                 kind: 3'(kind), data: 32'(data), vstart: 32'(vstart), sew: 3'(sew)};
  endfunction

  task automatic load_table();
    rows[0]  = make_row(enc_opv(0, 2, 3, 0, 1), 0, 0, 0, K_NONE, 0, 0, 0);
    rows[1]  = make_row(enc_vsetvli(5, 10, 0, 0), 20, 0, 1, K_RES, 20, 0, 0);
    rows[2]  = make_row(enc_vsetvli(5, 10, 1, 1), 100, 2, 1, K_RES, 32, 0, 0);
    rows[3]  = make_row(enc_vsetvli(5, 0, 2, 3), 0, 2, 1, K_RES, 64, 0, 0);
    rows[4]  = make_row(enc_vsetvli(6, 10, 0, 7), 10, 2, 1, K_RES, 10, 0, 0);
    rows[5]  = make_row(enc_vsetvli(6, 10, 2, 7), 5, 0, 1, K_RES, 0, 0, 0);
    rows[6]  = make_row(enc_csr(2, 'hC21, 0, 7), 0, 0, 1, K_RES, 'h8000_0000, 0, 0);
    rows[7]  = make_row(enc_vsetvli(5, 10, 0, 4), 7, 2, 1, K_RES, 0, 0, 0);
    rows[8]  = make_row(enc_vsetvli(5, 10, 1, 2), 50, 2, 1, K_RES, 50, 0, 0);
    rows[9]  = make_row(enc_csr(1, 'h008, 11, 8), 5, 0, 1, K_RES, 0, 0, 0);
    rows[10] = make_row(enc_csr(2, 'h008, 11, 8), 'h12, 0, 1, K_RES, 5, 0, 0);
    rows[11] = make_row(enc_csr(3, 'h008, 11, 8), 'h03, 0, 1, K_RES, 'h17, 0, 0);
    rows[12] = make_row(enc_csr(2, 'h008, 0, 8), 0, 0, 1, K_RES, 'h14, 0, 0);
    rows[13] = make_row(enc_csr(2, 'hC22, 0, 9), 0, 0, 1, K_RES, 32, 0, 0);
    rows[14] = make_row(enc_csr(2, 'hC20, 0, 9), 0, 0, 1, K_RES, 50, 0, 0);
    rows[15] = make_row(enc_opv(0, 8, 12, 0, 4), 0, 0, 1, K_VFU, 50, 'h14, 1);
    rows[16] = make_row(enc_csr(2, 'h008, 0, 8), 0, 0, 1, K_RES, 0, 0, 0);
    rows[17] = make_row(enc_csr(1, 'h008, 11, 8), 3, 0, 1, K_RES, 0, 0, 0);
    rows[18] = make_row(enc_opv('h0E, 4, 5, 4, 2), 9, 0, 1, K_SLD, 50, 3, 1);
    rows[19] = make_row(enc_vmem('h07, 0, 10, 3), 'h100, 0, 1, K_LSU, 50, 0, 0);
    rows[20] = make_row(enc_csr(1, 'h008, 11, 8), 7, 0, 1, K_RES, 0, 0, 0);
    rows[21] = make_row(enc_vmem('h07, 6, 10, 6), 'h200, 1, 1, K_LSU, 50, 7, 2);
    rows[22] = make_row(enc_opv('h25, 3, 2, 2, 1), 0, 1, 1, K_VFU, 50, 0, 1);
    rows[23] = make_row(enc_opv('h0F, 6, 7, 4, 8), 2, 1, 1, K_SLD, 50, 0, 1);
    rows[24] = make_row(enc_vmem('h27, 5, 10, 5), 'h300, 1, 1, K_LSU, 50, 0, 1);
    rows[25] = make_row(enc_vsetvli(5, 10, 0, 3), 300, 2, 1, K_RES, 256, 0, 0);
    rows[26] = make_row(enc_vsetvli(5, 0, 2, 0), 0, 2, 1, K_RES, 8, 0, 0);
    rows[27] = make_row(32'h0020_80b3, 0, 0, 0, K_NONE, 0, 0, 0);
    rows[28] = make_row(enc_csr(1, 'hC20, 11, 1), 4, 0, 0, K_NONE, 0, 0, 0);
    rows[29] = make_row(enc_vsetvli(0, 0, 0, 0), 0, 0, 0, K_NONE, 0, 0, 0);
    rows[30] = make_row(enc_csr(2, 'hC20, 0, 9), 0, 0, 1, K_RES, 8, 0, 0);
  endtask

  ////////////////////
  // Helpers
  ////////////////////

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bit(output logic b);
    b = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
  endtask

  task automatic drive_readies(input logic [1:0] sel);
    logic b;
    if (sel == 2'd0) begin
      vfu_ready_i   <= 1'b1;
      vlsu_ready_i  <= 1'b1;
      vsldu_ready_i <= 1'b1;
    end else begin
      take_bit(b);
      vfu_ready_i <= b;
      take_bit(b);
      vlsu_ready_i <= b;
      take_bit(b);
      vsldu_ready_i <= b;
    end
  endtask

  task automatic compare_hex(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s = 0x%08h, expected 0x%08h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report(input string msg);
    $display("%s", msg);
    err_cnt++;
  endtask

  function automatic logic target_ready(input int kind);
    case (kind)
      K_VFU:   target_ready = vfu_ready_i;
      K_LSU:   target_ready = vlsu_ready_i;
      default: target_ready = vsldu_ready_i;
    endcase
  endfunction

  function automatic ex_unit_e unit_of(input int kind);
    case (kind)
      K_VFU:   unit_of = VFU;
      K_LSU:   unit_of = LSU;
      K_SLD:   unit_of = SLD;
      default: unit_of = CON;
    endcase
  endfunction

  task automatic check_pulse(input row_t r, input int idx);
    if (r.kind == K_RES) begin
      if (!result_valid_o) report("Expected a result to the core, saw a unit dispatch");
      compare_hex("result_o.data", result_o.data, r.data);
      compare_hex("result_o.rd", 32'(result_o.rd), 32'(r.instr[11:7]));
      compare_hex("result_o.id", 32'(result_o.id), 32'(idx[3:0]));
      compare_hex("result_o.we", 32'(result_o.we), 32'd1);
      if (r.sel == 2'd2 && !(vfu_ready_i && vlsu_ready_i && vsldu_ready_i)) begin
        report("vsetvli changing LMUL retired while a unit was not ready");
      end
      // A legal vsetvli sets the LMUL that later dispatches carry
      if (r.instr[6:0] == 7'h57 && r.data != 32'd0) begin
        cur_lmul = r.instr[22:20];
      end
    end else begin
      if (!vreq_valid_o) report("Expected a unit dispatch, saw a result to the core");
      compare_hex("vreq_o.ex_unit", 32'(vreq_o.ex_unit), 32'(unit_of(int'(r.kind))));
      compare_hex("vreq_o.vl", 32'(vreq_o.vl), r.data);
      compare_hex("vreq_o.vstart", 32'(vreq_o.vstart), r.vstart);
      compare_hex("vreq_o.vtype.vsew", 32'(vreq_o.vtype.vsew), 32'(r.sew));
      compare_hex("vreq_o.vtype.vlmul", 32'(vreq_o.vtype.vlmul), 32'(cur_lmul));
      compare_hex("vreq_o.vtype.vill", 32'(vreq_o.vtype.vill), 32'd0);
      compare_hex("vreq_o.vd", 32'(vreq_o.vd), 32'(r.instr[11:7]));
      compare_hex("vreq_o.vs2", 32'(vreq_o.vs2), 32'(r.instr[24:20]));
      compare_hex("vreq_o.rs1", vreq_o.rs1, r.rs1);
      compare_hex("vreq_o.id", 32'(vreq_o.id), 32'(idx[3:0]));
      if (!target_ready(int'(r.kind))) report("Request dispatched to a unit that was not ready");
    end
  endtask

  // Issue one row and follow it to its pulse
  task automatic run_row(input int idx);
    row_t r;
    int   errs_before;
    logic hit;
    r = rows[idx];
    errs_before = err_cnt;
    while (!issue_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    issue_valid_i <= 1'b1;
    issue_req_i   <= '{instr: r.instr, rs1: r.rs1, id: idx[3:0]};
    drive_readies(r.sel);
    @(negedge clk_i);
    compare_hex("issue_resp_o.accept", 32'(issue_resp_o.accept), 32'(r.accept));
    compare_hex("issue_resp_o.writeback", 32'(issue_resp_o.writeback),
                32'(r.accept && r.kind == K_RES));
    compare_hex("issue_resp_o.loadstore", 32'(issue_resp_o.loadstore),
                32'(r.accept && r.kind == K_LSU));
    hit = vreq_valid_o | result_valid_o;
    while (!hit && r.accept) begin
      @(posedge clk_i);
      issue_valid_i <= 1'b0;
      drive_readies(r.sel);
      @(negedge clk_i);
      if (issue_ready_o !== 1'b0) report("issue_ready_o went high while a request waited");
      hit = vreq_valid_o | result_valid_o;
    end
    if (hit && !r.accept) report("A rejected instruction produced a pulse");
    if (hit && r.accept) check_pulse(r, idx);
    // Nothing more may leave for this row
    @(posedge clk_i);
    issue_valid_i <= 1'b0;
    drive_readies(2'd0);
    @(negedge clk_i);
    if (vreq_valid_o || result_valid_o) report("A request left the controller a second time");
    if (err_cnt == errs_before) begin
      $display("test %0d: ok", idx);
    end else begin
      $display("test %0d: failed", idx);
      tests_failed++;
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    rst_n_i       = 1'b0;
    issue_valid_i = 1'b0;
    issue_req_i   = '0;
    vfu_ready_i   = 1'b1;
    vlsu_ready_i  = 1'b1;
    vsldu_ready_i = 1'b1;
    lfsr_q        = 32'h894a_0ef7;
    cur_lmul      = 3'd0;
    cycle_cnt     = 0;
    err_cnt       = 0;
    tests_failed  = 0;
    load_table();
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    compare_hex("vreq_valid_o", 32'(vreq_valid_o), 32'd0);
    compare_hex("result_valid_o", 32'(result_valid_o), 32'd0);
    compare_hex("issue_resp_o.accept", 32'(issue_resp_o.accept), 32'd0);
    if (err_cnt == 0) begin
      $display("test reset: ok");
    end else begin
      $display("test reset: failed");
      tests_failed++;
    end
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    $display("%0d tests passed, %0d tests failed, %0d errors",
             NUM_ROWS + 1 - tests_failed, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+.
vctrl_pkg.sv
vinstr_decoder.sv
vcsr_file.sv
vreq_buffer.sv
issue_ctrl.sv
vctrl_top.sv
tb_vctrl.sv

// ==== Makefile ====
# Verilator build and run of the vector issue controller testbench

VERILATOR ?= verilator
TB_TOP    ?= tb_vctrl
RTL_TOP   ?= vctrl_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation finished: PASS
VFLAGS    ?= --binary --timing
RTL_SRCS  ?= vctrl_pkg.sv vinstr_decoder.sv vcsr_file.sv vreq_buffer.sv \
             issue_ctrl.sv vctrl_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only +incdir+. --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
